//--- hw/lpc_macros.svh
////////////////////////////////////////
// LPC front end sizing
// frame length and prediction order
////////////////////////////////////////
`ifndef LPC_MACROS_SVH
`define LPC_MACROS_SVH

`define FRAME_LEN 240 // samples per analysis frame
`define LPC_ORDER 10  // highest autocorrelation lag

`endif

//--- hw/fixedPointPkg.sv
////////////////////////////////////////
// Fixed-point arithmetic
// q15/q31 words, double-precision split, basic ops
////////////////////////////////////////
package fixedPointPkg;

	typedef logic signed [15:0] q15; // sample word
	typedef logic signed [31:0] q31; // accumulator word

	typedef struct packed {
		logic signed [15:0] high; // upper half, signed
		logic [15:0] low;         // raw lower bits, halved on output
	} dpfHalves;

	// one result word, seen whole or split into halves
	typedef union packed {
		q31 value;
		dpfHalves halves;
	} dpfWord;

	localparam q31 Q31Max = 32'sh7fffffff;
	localparam q31 Q31Min = 32'sh80000000;

	// acc + 2*a*b, saturating on the product and on the sum
	function automatic q31 macSat(input q31 acc, input q15 a, input q15 b, output logic ovf);
		q31 prod;
		logic signed [32:0] sum;
		ovf = 1'b0;
		prod = a * b;
		if (prod == 32'sh40000000) begin // -1 * -1 case
			prod = Q31Max;
			ovf = 1'b1;
		end else begin
			prod = prod <<< 1;
		end
		sum = acc + prod; // 33 bit, catches carry out
		if (sum[32] != sum[31]) begin
			ovf = 1'b1;
			return sum[32] ? Q31Min : Q31Max;
		end
		return sum[31:0];
	endfunction

	// redundant sign bits, zero maps to zero
	function automatic logic [4:0] normShift(input q31 x);
		logic [4:0] n;
		logic stop;
		n = '0;
		stop = 1'b0;
		if (x == 0) return '0;
		for (int i = 30; i >= 0; i--) begin
			if (!stop && x[i] == x[31]) n = n + 1'b1; // still a sign copy
			else stop = 1'b1;
		end
		return n;
	endfunction

	function automatic q31 shiftLeftSat(input q31 x, input logic [4:0] n);
		q31 shifted;
		shifted = x <<< n;
		if ((shifted >>> n) != x) return x[31] ? Q31Min : Q31Max; // bits lost
		return shifted;
	endfunction

endpackage

//--- hw/autocorrPkg.sv
////////////////////////////////////////
// Autocorrelation control types
////////////////////////////////////////
package autocorrPkg;

	typedef logic [7:0] frameAddr; // 0..239
	typedef logic [3:0] lagIndex;  // 0..10

	typedef enum logic [2:0] {
		phIdle,      // waiting on a full frame
		phEnergy,    // lag 0 pass
		phRescale,   // samples >>> 2 after overflow
		phNormalize, // shift count, emit lag 0
		phLag,       // lags 1..order
		phFinish     // wait out the output stage
	} enginePhase;

endpackage

//--- hw/memPort.sv
////////////////////////////////////////
// Frame memory port bundle
// one address, write strobe, write and read data
////////////////////////////////////////
interface memPort;
	import fixedPointPkg::*;
	import autocorrPkg::*;

	frameAddr address;
	logic writeEn;
	q15 writeData;
	q15 readData; // one cycle after address

	modport requester(output address, output writeEn, output writeData, input readData);
	modport memory(input address, input writeEn, input writeData, output readData);

endinterface

//--- hw/frameMemory.sv
////////////////////////////////////////
// Frame store, 240 x q15
// load port and engine port, registered reads
////////////////////////////////////////
`include "lpc_macros.svh"

module frameMemory (
	input logic clk,
	memPort.memory loadPort,
	memPort.memory enginePort
);
	import fixedPointPkg::*;

	q15 samples [`FRAME_LEN];

	// engine wins, the loader is held off while busy anyway
	always_ff @(posedge clk) begin
		if (enginePort.writeEn) begin
			samples[enginePort.address] <= enginePort.writeData; // rescale write back
		end else if (loadPort.writeEn) begin
			samples[loadPort.address] <= loadPort.writeData;
		end
	end

	always_ff @(posedge clk) begin
		loadPort.readData <= samples[loadPort.address];
		enginePort.readData <= samples[enginePort.address]; // old data on same cycle write
	end

endmodule

//--- hw/sampleWriter.sv
////////////////////////////////////////
// Sample loader
// writes strobed samples in order, flags a full frame
////////////////////////////////////////
`include "lpc_macros.svh"

module sampleWriter (
	input logic clk,
	input logic reset,
	input fixedPointPkg::q15 sampleIn,
	input logic sampleValid,
	input logic busy,
	output logic frameFull,
	memPort.requester loadPort
);
	import autocorrPkg::*;

	frameAddr writePtr;
	logic accept;
	logic lastSample;

	// frameFull cycle also blocked, busy is not up yet
	assign accept = sampleValid && !busy && !frameFull;
	assign lastSample = (writePtr == frameAddr'(`FRAME_LEN - 1));

	assign loadPort.address = writePtr;
	assign loadPort.writeEn = accept;
	assign loadPort.writeData = sampleIn;

	always_ff @(posedge clk) begin
		if (reset) begin
			writePtr <= '0;
			frameFull <= 1'b0;
		end else begin
			frameFull <= accept && lastSample; // one cycle pulse
			if (accept) writePtr <= lastSample ? '0 : writePtr + 1'b1;
		end
	end

endmodule

//--- hw/autocorrEngine.sv
////////////////////////////////////////
// Autocorrelation engine
// energy pass with rescale, normalize, lags 1..order
////////////////////////////////////////
`include "lpc_macros.svh"

module autocorrEngine (
	input logic clk,
	input logic reset,
	input logic frameFull,
	output logic busy,
	memPort.requester enginePort,
	output fixedPointPkg::dpfWord resultWord,
	output autocorrPkg::lagIndex resultLag,
	output logic resultStrobe,
	output logic lastResult
);
	import fixedPointPkg::*;
	import autocorrPkg::*;

	enginePhase phase;
	frameAddr idx;         // sample pointer, also finish counter
	lagIndex lag;          // current lag
	logic step;            // 0: fetch j, 1: fetch j+lag or write back
	logic pend;            // a product's data arrives this cycle
	logic ovfSticky;       // any saturation in the energy pass
	q31 acc;
	q15 sampleJ;           // held x[j] for the lag product
	logic [4:0] normCount; // shift taken from lag 0
	q15 macA;
	q31 macNext;
	logic macOvf;
	logic [4:0] energyNorm;
	frameAddr lagLimit;

	assign macA = (phase == phLag) ? sampleJ : enginePort.readData; // square vs cross product
	assign energyNorm = normShift(acc);
	assign lagLimit = frameAddr'(`FRAME_LEN) - frameAddr'(lag); // products per lag

	always_comb begin
		macNext = macSat(acc, macA, enginePort.readData, macOvf);
	end

	////////////////////////////////////////
	// memory port drive
	////////////////////////////////////////
	always_comb begin
		enginePort.address = idx;
		enginePort.writeEn = 1'b0;
		enginePort.writeData = enginePort.readData >>> 2; // sign kept
		case (phase)
			phRescale: enginePort.writeEn = step; // data for idx is back
			phLag: if (step) enginePort.address = idx + frameAddr'(lag);
			default: ;
		endcase
	end

	////////////////////////////////////////
	// sequencer
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		resultStrobe <= 1'b0;
		lastResult <= 1'b0;
		if (reset) begin
			phase <= phIdle;
			busy <= 1'b0;
			step <= 1'b0;
			pend <= 1'b0;
			ovfSticky <= 1'b0;
		end else begin
			case (phase)
				phIdle: begin
					if (frameFull) begin
						busy <= 1'b1;
						phase <= phEnergy;
						idx <= '0;
						pend <= 1'b0;
						acc <= 32'sd1; // energy starts from one
						ovfSticky <= 1'b0;
					end
				end
				phEnergy: begin
					if (pend) begin
						acc <= macNext;
						ovfSticky <= ovfSticky | macOvf;
					end
					if (idx != frameAddr'(`FRAME_LEN)) begin
						idx <= idx + 1'b1; // stream one read per cycle
						pend <= 1'b1;
					end else begin
						pend <= 1'b0;
						if (!pend && ovfSticky) begin // pass drained, overflowed
							phase <= phRescale;
							idx <= '0;
							step <= 1'b0;
						end else if (!pend) begin
							phase <= phNormalize;
						end
					end
				end
				phRescale: begin
					step <= ~step;
					if (step) begin
						idx <= idx + 1'b1;
					end else if (idx == frameAddr'(`FRAME_LEN)) begin
						phase <= phEnergy; // run the energy pass again
						idx <= '0;
						step <= 1'b0;
						pend <= 1'b0;
						acc <= 32'sd1;
						ovfSticky <= 1'b0;
					end
				end
				phNormalize: begin
					normCount <= energyNorm;
					resultWord.value <= shiftLeftSat(acc, energyNorm); // lag 0
					resultLag <= '0;
					resultStrobe <= 1'b1;
					phase <= phLag;
					lag <= 4'd1;
					idx <= '0;
					step <= 1'b0;
					pend <= 1'b0;
					acc <= '0;
				end
				phLag: begin
					if (step) begin
						sampleJ <= enginePort.readData; // x[j]
						idx <= idx + 1'b1;
						pend <= 1'b1;
						step <= 1'b0;
					end else begin
						if (pend) acc <= macNext; // x[j] * x[j+lag]
						pend <= 1'b0;
						if (idx != lagLimit) begin
							step <= 1'b1;
						end else if (!pend) begin
							resultWord.value <= shiftLeftSat(acc, normCount);
							resultLag <= lag;
							resultStrobe <= 1'b1;
							idx <= '0;
							acc <= '0;
							if (lag == lagIndex'(`LPC_ORDER)) begin
								lastResult <= 1'b1;
								phase <= phFinish;
							end else begin
								lag <= lag + 1'b1;
							end
						end
					end
				end
				phFinish: begin
					// busy drops with frameDone, two cycles after the last strobe
					if (idx == '0) begin
						idx <= 8'd1;
					end else begin
						busy <= 1'b0;
						phase <= phIdle;
					end
				end
				default: phase <= phIdle;
			endcase
		end
	end

endmodule

//--- hw/resultWriter.sv
////////////////////////////////////////
// Result output stage
// registers high/low split and lag, flags frame end
////////////////////////////////////////
module resultWriter (
	input logic clk,
	input logic reset,
	input fixedPointPkg::dpfWord resultWord,
	input autocorrPkg::lagIndex resultLag,
	input logic resultStrobe,
	input logic lastResult,
	output fixedPointPkg::q15 rHigh,
	output logic [15:0] rLow,
	output autocorrPkg::lagIndex rLag,
	output logic rValid,
	output logic frameDone
);
	logic lastHeld; // rValid now carries the final lag

	always_ff @(posedge clk) begin
		if (resultStrobe) begin
			rHigh <= resultWord.halves.high;
			rLow <= {1'b0, resultWord.halves.low[15:1]}; // low half >> 1
			rLag <= resultLag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rValid <= 1'b0;
			lastHeld <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			rValid <= resultStrobe;
			lastHeld <= resultStrobe && lastResult;
			frameDone <= rValid && lastHeld; // one cycle after last rValid
		end
	end

endmodule

//--- hw/lpcAutocorr.sv
////////////////////////////////////////
// LPC autocorrelation subsystem
// loader, frame store, engine, output stage
////////////////////////////////////////
module lpcAutocorr (
	input logic clk,
	input logic reset,
	input fixedPointPkg::q15 sampleIn,
	input logic sampleValid,
	output logic busy,
	output fixedPointPkg::q15 rHigh,
	output logic [15:0] rLow,
	output autocorrPkg::lagIndex rLag,
	output logic rValid,
	output logic frameDone
);
	import fixedPointPkg::*;
	import autocorrPkg::*;

	logic frameFull;
	dpfWord resultWord;
	lagIndex resultLag;
	logic resultStrobe;
	logic lastResult;

	memPort loadPort();   // loader side
	memPort enginePort(); // engine side

	frameMemory frameStore (
		.clk(clk),
		.loadPort(loadPort.memory),
		.enginePort(enginePort.memory)
	);

	sampleWriter loader (
		.clk(clk),
		.reset(reset),
		.sampleIn(sampleIn),
		.sampleValid(sampleValid),
		.busy(busy),
		.frameFull(frameFull),
		.loadPort(loadPort.requester)
	);

	autocorrEngine engine (
		.clk(clk),
		.reset(reset),
		.frameFull(frameFull),
		.busy(busy),
		.enginePort(enginePort.requester),
		.resultWord(resultWord),
		.resultLag(resultLag),
		.resultStrobe(resultStrobe),
		.lastResult(lastResult)
	);

	resultWriter outStage (
		.clk(clk),
		.reset(reset),
		.resultWord(resultWord),
		.resultLag(resultLag),
		.resultStrobe(resultStrobe),
		.lastResult(lastResult),
		.rHigh(rHigh),
		.rLow(rLow),
		.rLag(rLag),
		.rValid(rValid),
		.frameDone(frameDone)
	);

endmodule

//--- bench/tbLpcAutocorr.sv
////////////////////////////////////////
// Testbench for the LPC autocorrelation subsystem
// random, full-scale, zero and busy-strobe frames
////////////////////////////////////////
`include "lpc_macros.svh"

module tbLpcAutocorr;
	timeunit 1ns;
	timeprecision 1ps;
	import fixedPointPkg::*;
	import autocorrPkg::*;

	localparam int ClockPeriod = 10;
	localparam int Results = `LPC_ORDER + 1;
	// worst frame: gapped load, 4 energy passes, 3 rescales, lag loops, tail
	localparam int FrameCycles = 2 * `FRAME_LEN + 4 * (`FRAME_LEN + 4)
		+ 3 * (2 * `FRAME_LEN + 2) + `LPC_ORDER * (2 * `FRAME_LEN + 4) + 16;
	localparam int WatchdogCycles = 20 * FrameCycles;
	localparam longint Q31Hi = 64'sd2147483647;
	localparam longint Q31Lo = -64'sd2147483648;

	logic clk;
	logic reset;
	q15 sampleIn;
	logic sampleValid;
	logic busy;
	q15 rHigh;
	logic [15:0] rLow;
	lagIndex rLag;
	logic rValid;
	logic frameDone;

	integer seed;
	q15 frameBuf [`FRAME_LEN];    // frame as the DUT should store it
	q15 expHigh [Results];
	logic [15:0] expLow [Results];
	int valueErrors = 0;
	int protocolErrors = 0;
	int framesSent = 0;
	int doneCount = 0;

	lpcAutocorr DUT (
		.clk(clk),
		.reset(reset),
		.sampleIn(sampleIn),
		.sampleValid(sampleValid),
		.busy(busy),
		.rHigh(rHigh),
		.rLow(rLow),
		.rLag(rLag),
		.rValid(rValid),
		.frameDone(frameDone)
	);

	initial begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// reference model, 64 bit math clipped to q31
	////////////////////////////////////////
	function automatic longint clampQ31(input longint v);
		if (v > Q31Hi) return Q31Hi;
		if (v < Q31Lo) return Q31Lo;
		return v;
	endfunction

	// acc + 2ab, product and sum both clipped
	function automatic longint macRef(input longint acc, input longint a, input longint b,
			output logic ovf);
		longint prod;
		longint sum;
		prod = clampQ31(2 * a * b);
		sum = clampQ31(acc + prod);
		ovf = (prod != 2 * a * b) || (sum != acc + prod); // any clipping
		return sum;
	endfunction

	// largest left shift that still fits 32 bits
	function automatic int normRef(input longint v);
		int n;
		n = 0;
		if (v == 0) return 0;
		while (n < 31 && clampQ31(v <<< (n + 1)) == (v <<< (n + 1))) begin
			n++;
		end
		return n;
	endfunction

	function automatic longint shiftRef(input longint v, input int n);
		return clampQ31(v <<< n);
	endfunction

	// expected outputs for frameBuf
	function automatic void refAutocorr();
		q15 work [`FRAME_LEN];
		longint acc;
		logic ovf;
		logic anyOvf;
		int norm;
		logic [31:0] r;
		work = frameBuf;
		do begin
			acc = 1; // energy starts at one
			anyOvf = 1'b0;
			for (int j = 0; j < `FRAME_LEN; j++) begin
				acc = macRef(acc, work[j], work[j], ovf);
				anyOvf |= ovf;
			end
			if (anyOvf) begin
				for (int j = 0; j < `FRAME_LEN; j++) begin
					work[j] = work[j] >>> 2; // scale down, keep sign
				end
			end
		end while (anyOvf);
		norm = normRef(acc);
		for (int k = 0; k < Results; k++) begin
			if (k > 0) begin
				acc = 0;
				for (int j = 0; j < `FRAME_LEN - k; j++) begin
					acc = macRef(acc, work[j], work[j + k], ovf);
				end
			end
			r = 32'(shiftRef(acc, norm));
			expHigh[k] = r[31:16];
			expLow[k] = {1'b0, r[15:1]}; // low half halved
		end
	endfunction

	////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////
	task automatic loadFrame(input logic withGaps);
		for (int i = 0; i < `FRAME_LEN; i++) begin
			@(posedge clk);
			if (withGaps && (($random(seed) & 3) == 0)) begin
				sampleValid <= 1'b0; // idle gap between strobes
				@(posedge clk);
			end
			sampleIn <= frameBuf[i];
			sampleValid <= 1'b1;
		end
		@(posedge clk);
		sampleValid <= 1'b0;
		framesSent++;
	endtask

	task automatic waitFrameDone(input string label);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (!frameDone && cycles < FrameCycles) begin
			@(posedge clk);
			cycles++;
		end
		assert (frameDone) else begin
			protocolErrors++;
			$display("no frameDone within %0d cycles for the %s frame", FrameCycles, label);
		end
	endtask

	task automatic waitBusy();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (!busy && cycles < 16) begin
			@(posedge clk);
			cycles++;
		end
		assert (busy) else begin
			protocolErrors++;
			$display("busy did not rise after a full frame was loaded");
		end
	endtask

	task automatic sendFrame(input string label, input logic withGaps);
		loadFrame(withGaps);
		waitFrameDone(label);
		repeat (3) @(posedge clk); // let the compare side settle
	endtask

	////////////////////////////////////////
	// result comparison
	////////////////////////////////////////
	initial begin : compareResults
		int lagSeen;
		lagSeen = 0;
		forever begin
			@(posedge clk);
			if (reset) begin
				lagSeen = 0;
			end else begin
				if (rValid) begin
					assert (lagSeen < Results) else begin
						protocolErrors++;
						$display("more than %0d results in one frame", Results);
					end
					if (lagSeen < Results) begin
						assert (rLag == lagIndex'(lagSeen)) else begin
							valueErrors++;
							$display("CHECK FAILED at %0t: lag %0d, expected %0d",
								$time, rLag, lagSeen);
						end
						assert (rHigh == expHigh[lagSeen]) else begin
							valueErrors++;
							$display("CHECK FAILED at %0t: lag %0d high %0d, expected %0d",
								$time, lagSeen, rHigh, expHigh[lagSeen]);
						end
						assert (rLow == expLow[lagSeen]) else begin
							valueErrors++;
							$display("CHECK FAILED at %0t: lag %0d low %0d, expected %0d",
								$time, lagSeen, rLow, expLow[lagSeen]);
						end
					end
					lagSeen++;
				end
				if (frameDone) begin
					assert (lagSeen == Results) else begin
						protocolErrors++;
						$display("frameDone came after %0d results instead of %0d",
							lagSeen, Results);
					end
					assert (!busy) else begin
						protocolErrors++;
						$display("busy still high when frameDone pulsed");
					end
					doneCount++;
					lagSeen = 0;
				end
			end
		end
	end

	initial begin : watchdog
		#(WatchdogCycles * ClockPeriod);
		$display("watchdog expired after %0d cycles, simulation stopped", WatchdogCycles);
		$display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin : stimulus
		seed = 32'h63e5b56e;
		reset = 1'b1;
		sampleIn = '0;
		sampleValid = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		repeat (50) begin // nothing loaded, outputs stay quiet
			@(posedge clk);
			assert (!rValid && !frameDone && !busy) else begin
				protocolErrors++;
				$display("outputs active at %0t with no samples loaded", $time);
			end
		end

		for (int i = 0; i < `FRAME_LEN; i++) begin
			frameBuf[i] = q15'($random(seed) % 512); // small values
		end
		refAutocorr();
		sendFrame("small random", 1'b1);

		for (int i = 0; i < `FRAME_LEN; i++) begin
			frameBuf[i] = q15'($random(seed)); // full scale
		end
		frameBuf[17] = -16'sd32768; // square saturates too
		refAutocorr();
		sendFrame("full-scale", 1'b0);

		for (int i = 0; i < `FRAME_LEN; i++) begin
			frameBuf[i] = '0;
		end
		for (int k = 0; k < Results; k++) begin
			expHigh[k] = '0;
			expLow[k] = '0;
		end
		expHigh[0] = 16'sd16384; // energy of one, normalized
		sendFrame("all-zero", 1'b0);

		for (int i = 0; i < `FRAME_LEN; i++) begin
			frameBuf[i] = q15'($random(seed) % 4096);
		end
		refAutocorr();
		loadFrame(1'b0);
		waitBusy();
		repeat (100) begin // junk while busy
			@(posedge clk);
			sampleIn <= q15'($random(seed));
			sampleValid <= 1'b1;
		end
		@(posedge clk);
		sampleValid <= 1'b0;
		waitFrameDone("busy strobe");
		repeat (3) @(posedge clk);

		// next frame has to start at address 0
		for (int i = 0; i < `FRAME_LEN; i++) begin
			frameBuf[i] = q15'($random(seed) % 2048);
		end
		refAutocorr();
		sendFrame("after busy strobe", 1'b1);

		repeat (10) @(posedge clk);
		assert (doneCount == framesSent) else begin
			protocolErrors++;
			$display("%0d frames loaded but %0d frameDone pulses seen", framesSent, doneCount);
		end
		$display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+hw
hw/fixedPointPkg.sv
hw/autocorrPkg.sv
hw/memPort.sv
hw/frameMemory.sv
hw/sampleWriter.sv
hw/autocorrEngine.sv
hw/resultWriter.sv
hw/lpcAutocorr.sv
bench/tbLpcAutocorr.sv

//--- Makefile
# Verilator build and run for the LPC autocorrelation testbench

VERILATOR ?= verilator
TOP ?= tbLpcAutocorr
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard hw/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
